// File: common/cache_consts.svh
// ==========================================================================
// Geometry of the L1 data cache: ways, lines, words per line and the
// widths derived from them. Include wherever a width or count is needed.
// ==========================================================================
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Basic geometry
`define CACHE_WAYS      4
`define CACHE_LINES     256
`define WORDS_PER_LINE  4

// Address split, 32-bit byte address
`define ADDR_W          32
`define BYTE_OFF_W      2
`define WORD_SEL_W      2
`define INDEX_W         8
`define TAG_W           (`ADDR_W - `INDEX_W - `WORD_SEL_W - `BYTE_OFF_W)

// Line and way widths
`define LINE_W          (`WORDS_PER_LINE * 32)
`define LINE_BYTES      (`LINE_W / 8)
`define WAY_W           2

`endif

// File: common/cache_pkg.sv
// ==========================================================================
// Shared types of the L1 data cache. Modules import it inside their body
// and use scoped names for ports.
// ==========================================================================
`include "cache_consts.svh"

package cache_pkg;

	typedef logic [`TAG_W-1:0]      tag_t;
	typedef logic [`INDEX_W-1:0]    index_t;
	typedef logic [`WAY_W-1:0]      way_t;
	typedef logic [`LINE_W-1:0]     line_t;
	typedef logic [`LINE_BYTES-1:0] line_strb_t;

	// Field view of a byte address
	typedef struct packed {
		tag_t                   tag;
		index_t                 index;
		logic [`WORD_SEL_W-1:0] word;
		logic [`BYTE_OFF_W-1:0] offset;
	} cache_addr_s;

	// Same word read as a raw address or split into its fields
	typedef union packed {
		logic [`ADDR_W-1:0] raw;
		cache_addr_s        f;
	} cache_addr_u;

endpackage

// File: rtl/line_data_store.sv
// ==========================================================================
// Line data arrays, one per way, with byte enables. Reads are registered
// for all ways and i_way picks the line returned on o_rline.
// ==========================================================================
`include "cache_consts.svh"

module line_data_store (
	input  logic                  clk_i,
	input  cache_pkg::index_t     i_index,
	input  logic                  i_we,
	input  cache_pkg::way_t       i_way,
	input  cache_pkg::line_strb_t i_strb,
	input  cache_pkg::line_t      i_wdata,
	output cache_pkg::line_t      o_rline
);
	import cache_pkg::*;

	line_t mem [`CACHE_WAYS][`CACHE_LINES];
	line_t rd_q [`CACHE_WAYS];

	always_ff @(posedge clk_i) begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (i_we && i_way == way_t'(w)) begin
				for (int b = 0; b < `LINE_BYTES; b++) begin
					if (i_strb[b]) begin
						mem[w][i_index][b*8 +: 8] <= i_wdata[b*8 +: 8];
					end
				end
			end
			// Old contents on a same-cycle write
			rd_q[w] <= mem[w][i_index];
		end
	end

	assign o_rline = rd_q[i_way];

endmodule

// File: l1_cache/tag_store.sv
// ==========================================================================
// Tag and valid arrays for all ways. Serves a controller lookup port and a
// snoop port, takes fill and invalidation writes, and clears every valid
// bit after reset before raising o_init_done.
// ==========================================================================
`include "cache_consts.svh"

module tag_store (
	input  logic              clk_i,
	input  logic              rst_n,
	output logic              o_init_done,
	input  cache_pkg::index_t i_lookup_index,
	input  cache_pkg::tag_t   i_lookup_tag,
	output logic              o_hit,
	output cache_pkg::way_t   o_hit_way,
	input  logic              i_fill_we,
	input  cache_pkg::way_t   i_fill_way,
	input  logic              i_fill_valid,
	input  cache_pkg::index_t i_snoop_index,
	input  cache_pkg::tag_t   i_snoop_tag,
	output logic              o_snoop_hit,
	output cache_pkg::way_t   o_snoop_hit_way,
	input  logic              i_inval_we,
	input  cache_pkg::way_t   i_inval_way
);
	import cache_pkg::*;

	tag_t                   tag_mem [`CACHE_WAYS][`CACHE_LINES];
	logic                   valid_mem [`CACHE_WAYS][`CACHE_LINES];
	tag_t                   lk_tag_q [`CACHE_WAYS];
	logic                   lk_valid_q [`CACHE_WAYS];
	tag_t                   sn_tag_q [`CACHE_WAYS];
	logic                   sn_valid_q [`CACHE_WAYS];
	logic [`CACHE_WAYS-1:0] lk_match;
	logic [`CACHE_WAYS-1:0] sn_match;
	index_t                 sweep_idx;
	logic                   init_done;

	// Valid sweep, one index per cycle
	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			sweep_idx <= '0;
			init_done <= 1'b0;
		end else if (!init_done) begin
			sweep_idx <= sweep_idx + 1'b1;
			if (&sweep_idx) begin
				init_done <= 1'b1;
			end
		end
	end

	assign o_init_done = init_done;

	always_ff @(posedge clk_i) begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (!init_done) begin
				valid_mem[w][sweep_idx] <= 1'b0;
			end else begin
				if (i_fill_we && i_fill_way == way_t'(w)) begin
					tag_mem[w][i_lookup_index]   <= i_lookup_tag;
					valid_mem[w][i_lookup_index] <= i_fill_valid;
				end
				// Comes last so it overrides a fill to the same entry
				if (i_inval_we && i_inval_way == way_t'(w)) begin
					valid_mem[w][i_snoop_index] <= 1'b0;
				end
			end
			lk_tag_q[w]   <= tag_mem[w][i_lookup_index];
			lk_valid_q[w] <= valid_mem[w][i_lookup_index];
			sn_tag_q[w]   <= tag_mem[w][i_snoop_index];
			sn_valid_q[w] <= valid_mem[w][i_snoop_index];
		end
	end

	always_comb begin
		o_hit           = 1'b0;
		o_hit_way       = '0;
		o_snoop_hit     = 1'b0;
		o_snoop_hit_way = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			lk_match[w] = lk_valid_q[w] && (lk_tag_q[w] == i_lookup_tag);
			sn_match[w] = sn_valid_q[w] && (sn_tag_q[w] == i_snoop_tag);
			if (lk_match[w]) begin
				o_hit     = 1'b1;
				o_hit_way = way_t'(w);
			end
			if (sn_match[w]) begin
				o_snoop_hit     = 1'b1;
				o_snoop_hit_way = way_t'(w);
			end
		end
	end

	// Fills only follow a miss, so a tag never lives in two ways
	assert property (@(posedge clk_i) disable iff (!rst_n || !init_done)
		$onehot0(lk_match));

endmodule

// File: l1_cache/snoop_checker.sv
// ==========================================================================
// Incoming snoop pipeline. Accepts a snoop address while not busy, reads
// the tags one cycle later and invalidates the matching way. Runs beside
// the request controller.
// ==========================================================================
module snoop_checker (
	input  logic              clk_i,
	input  logic              rst_n,
	input  logic              i_snoop_valid,
	input  logic [31:0]       i_snoop_addr,
	output logic              o_snoop_busy,
	output cache_pkg::index_t o_snoop_index,
	output cache_pkg::tag_t   o_snoop_tag,
	input  logic              i_snoop_hit,
	input  cache_pkg::way_t   i_snoop_hit_way,
	output logic              o_inval_we,
	output cache_pkg::way_t   o_inval_way,
	output logic              o_inval_seen,
	output cache_pkg::index_t o_inval_index
);
	import cache_pkg::*;

	typedef enum logic [1:0] {
		SN_IDLE, SN_READ, SN_CHECK
	} state_e;

	state_e      state;
	cache_addr_u in_addr;
	cache_addr_u snoop_q;

	assign in_addr.raw  = i_snoop_addr;
	assign o_snoop_busy = (state != SN_IDLE);

	// Told to the controller in the accept cycle, for a fill in flight
	assign o_inval_seen  = i_snoop_valid && !o_snoop_busy;
	assign o_inval_index = in_addr.f.index;

	assign o_snoop_index = snoop_q.f.index;
	assign o_snoop_tag   = snoop_q.f.tag;
	assign o_inval_we    = (state == SN_CHECK) && i_snoop_hit;
	assign o_inval_way   = i_snoop_hit_way;

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			state   <= SN_IDLE;
			snoop_q <= '0;
		end else begin
			case (state)
				SN_IDLE: begin
					if (o_inval_seen) begin
						snoop_q <= in_addr;
						state   <= SN_READ;
					end
				end
				SN_READ: begin
					state <= SN_CHECK;
				end
				default: begin
					state <= SN_IDLE;
				end
			endcase
		end
	end

	// Busy covers exactly the two pipeline cycles after acceptance
	assert property (@(posedge clk_i) disable iff (!rst_n)
		o_inval_seen |=> o_snoop_busy ##1 o_snoop_busy ##1 !o_snoop_busy);

endmodule

// File: l1_cache/rw_controller.sv
// ==========================================================================
// Request controller of the L1 data cache. Takes one read or write at a
// time, looks it up in the tag store, fills lines on read misses and
// forwards every write to memory, updating the line on a hit.
// ==========================================================================
`include "cache_consts.svh"

module rw_controller (
	input  logic                  clk_i,
	input  logic                  rst_n,
	input  logic                  i_init_done,
	input  logic                  i_rd_valid,
	output logic                  o_rd_ready,
	input  logic [31:0]           i_rd_addr,
	output logic                  o_rsp_valid,
	input  logic                  i_rsp_ready,
	output logic [31:0]           o_rsp_data,
	input  logic                  i_wr_valid,
	output logic                  o_wr_ready,
	input  logic [31:0]           i_wr_addr,
	input  logic [31:0]           i_wr_data,
	input  logic [3:0]            i_wr_strb,
	output logic                  o_wr_done,
	output logic                  o_mem_rd_valid,
	input  logic                  i_mem_rd_ready,
	output logic [31:0]           o_mem_rd_addr,
	input  logic                  i_mem_rdata_valid,
	input  logic [31:0]           i_mem_rdata,
	output logic                  o_mem_wr_valid,
	input  logic                  i_mem_wr_ready,
	output logic [31:0]           o_mem_wr_addr,
	output logic [31:0]           o_mem_wr_data,
	output logic [3:0]            o_mem_wr_strb,
	input  logic                  i_mem_wr_done,
	output logic                  o_snoop_valid,
	output logic [31:0]           o_snoop_addr,
	input  logic                  i_snoop_stall,
	input  logic                  i_inval_seen,
	input  cache_pkg::index_t     i_inval_index,
	output cache_pkg::index_t     o_lookup_index,
	output cache_pkg::tag_t       o_lookup_tag,
	input  logic                  i_hit,
	input  cache_pkg::way_t       i_hit_way,
	output logic                  o_fill_we,
	output cache_pkg::way_t       o_fill_way,
	output logic                  o_fill_valid,
	output logic                  o_data_we,
	output cache_pkg::way_t       o_data_way,
	output cache_pkg::line_strb_t o_data_strb,
	output cache_pkg::line_t      o_data_wdata,
	input  cache_pkg::line_t      i_data_rline
);
	import cache_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE, ST_CHECK1, ST_CHECK2, ST_RESP,
		ST_FILL_REQ, ST_FILL_DATA, ST_WR_ISSUE, ST_WR_WAIT
	} state_e;

	state_e                 state;
	cache_addr_u            req_addr;
	cache_addr_u            addr_q;
	logic                   is_write;
	logic [31:0]            wdata_q;
	logic [3:0]             wstrb_q;
	logic [31:0]            rsp_data_q;
	line_t                  fill_line;
	line_t                  fill_full;
	logic [`WORD_SEL_W-1:0] beat_cnt;
	way_t                   victim_q;
	way_t                   repl_cnt;
	logic                   fill_valid_q;
	logic                   wr_done_q;
	logic                   accept_rd;
	logic                   accept_wr;
	logic                   last_beat;
	logic                   snoop_on_line;

	// Reads win over writes; writes also wait out an outgoing snoop stall
	assign o_rd_ready = (state == ST_IDLE) && i_init_done;
	assign o_wr_ready = (state == ST_IDLE) && i_init_done && !i_rd_valid && !i_snoop_stall;
	assign accept_rd  = i_rd_valid && o_rd_ready;
	assign accept_wr  = i_wr_valid && o_wr_ready;
	assign req_addr.raw = accept_rd ? i_rd_addr : i_wr_addr;

	assign last_beat = (state == ST_FILL_DATA) && i_mem_rdata_valid &&
		(int'(beat_cnt) == `WORDS_PER_LINE - 1);

	// A snoop to the line being requested spoils the coming fill
	assign snoop_on_line = i_inval_seen &&
		(i_inval_index == ((state == ST_IDLE) ? req_addr.f.index : addr_q.f.index));

	// Current beat dropped into the line collected so far
	always_comb begin
		fill_full = fill_line;
		fill_full[beat_cnt*32 +: 32] = i_mem_rdata;
	end

	assign o_rsp_valid    = (state == ST_RESP);
	assign o_rsp_data     = rsp_data_q;
	assign o_mem_rd_valid = (state == ST_FILL_REQ);
	assign o_mem_rd_addr  = {addr_q.f.tag, addr_q.f.index, {(`WORD_SEL_W + `BYTE_OFF_W){1'b0}}};
	assign o_mem_wr_valid = (state == ST_WR_ISSUE);
	assign o_mem_wr_addr  = addr_q.raw;
	assign o_mem_wr_data  = wdata_q;
	assign o_mem_wr_strb  = wstrb_q;
	assign o_wr_done      = wr_done_q;
	assign o_snoop_valid  = wr_done_q;
	assign o_snoop_addr   = addr_q.raw;

	assign o_lookup_index = addr_q.f.index;
	assign o_lookup_tag   = addr_q.f.tag;
	assign o_fill_we      = last_beat;
	assign o_fill_way     = victim_q;
	assign o_fill_valid   = fill_valid_q && !snoop_on_line;

	// Fill writes the whole line, a write hit only the strobed bytes
	assign o_data_we    = last_beat || ((state == ST_CHECK2) && is_write && i_hit);
	assign o_data_way   = (state == ST_FILL_DATA) ? victim_q : i_hit_way;
	assign o_data_strb  = (state == ST_FILL_DATA) ? '1 :
		line_strb_t'(wstrb_q) << (addr_q.f.word * 4);
	assign o_data_wdata = (state == ST_FILL_DATA) ? fill_full : {`WORDS_PER_LINE{wdata_q}};

	// Victim selection
	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			repl_cnt <= '0;
		end else begin
			repl_cnt <= repl_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			state        <= ST_IDLE;
			addr_q       <= '0;
			is_write     <= 1'b0;
			beat_cnt     <= '0;
			victim_q     <= '0;
			fill_valid_q <= 1'b0;
			wr_done_q    <= 1'b0;
		end else begin
			wr_done_q <= 1'b0;
			if (state != ST_IDLE && snoop_on_line) begin
				fill_valid_q <= 1'b0;
			end
			case (state)
				ST_IDLE: begin
					if (accept_rd || accept_wr) begin
						addr_q       <= req_addr;
						is_write     <= !accept_rd;
						fill_valid_q <= !snoop_on_line;
						state        <= ST_CHECK1;
					end
				end
				// Tag and data arrays are read at the end of this cycle
				ST_CHECK1: begin
					state <= ST_CHECK2;
				end
				ST_CHECK2: begin
					if (is_write) begin
						state <= ST_WR_ISSUE;
					end else if (i_hit) begin
						state <= ST_RESP;
					end else begin
						victim_q <= repl_cnt;
						beat_cnt <= '0;
						state    <= ST_FILL_REQ;
					end
				end
				ST_RESP: begin
					if (i_rsp_ready) begin
						state <= ST_IDLE;
					end
				end
				ST_FILL_REQ: begin
					if (i_mem_rd_ready) begin
						state <= ST_FILL_DATA;
					end
				end
				ST_FILL_DATA: begin
					if (i_mem_rdata_valid) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (last_beat) begin
							state <= ST_RESP;
						end
					end
				end
				ST_WR_ISSUE: begin
					if (i_mem_wr_ready) begin
						state <= ST_WR_WAIT;
					end
				end
				ST_WR_WAIT: begin
					if (i_mem_wr_done) begin
						wr_done_q <= 1'b1;
						state     <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept_wr) begin
			wdata_q <= i_wr_data;
			wstrb_q <= i_wr_strb;
		end
		if (state == ST_FILL_DATA && i_mem_rdata_valid) begin
			fill_line <= fill_full;
		end
		// Word select from the hit line, or from the finished fill
		if (state == ST_CHECK2 && !is_write) begin
			rsp_data_q <= i_data_rline[addr_q.f.word*32 +: 32];
		end else if (last_beat) begin
			rsp_data_q <= fill_full[addr_q.f.word*32 +: 32];
		end
	end

	// Response held steady under back-pressure
	assert property (@(posedge clk_i) disable iff (!rst_n)
		o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp_data));

endmodule

// File: l1_cache/l1_cache_top.sv
// ==========================================================================
// L1 data cache top level. Connects the request controller, the snoop
// checker and the tag and data stores to the processor, memory and snoop
// ports.
// ==========================================================================
module l1_cache_top (
	input  logic        clk_i,
	input  logic        rst_n,
	input  logic        i_rd_valid,
	output logic        o_rd_ready,
	input  logic [31:0] i_rd_addr,
	output logic        o_rsp_valid,
	input  logic        i_rsp_ready,
	output logic [31:0] o_rsp_data,
	input  logic        i_wr_valid,
	output logic        o_wr_ready,
	input  logic [31:0] i_wr_addr,
	input  logic [31:0] i_wr_data,
	input  logic [3:0]  i_wr_strb,
	output logic        o_wr_done,
	output logic        o_mem_rd_valid,
	input  logic        i_mem_rd_ready,
	output logic [31:0] o_mem_rd_addr,
	input  logic        i_mem_rdata_valid,
	input  logic [31:0] i_mem_rdata,
	output logic        o_mem_wr_valid,
	input  logic        i_mem_wr_ready,
	output logic [31:0] o_mem_wr_addr,
	output logic [31:0] o_mem_wr_data,
	output logic [3:0]  o_mem_wr_strb,
	input  logic        i_mem_wr_done,
	input  logic        i_snoop_valid,
	input  logic [31:0] i_snoop_addr,
	output logic        o_snoop_busy,
	output logic        o_snoop_valid,
	output logic [31:0] o_snoop_addr,
	input  logic        i_snoop_stall
);
	import cache_pkg::*;

	logic       init_done;
	logic       inval_seen;
	index_t     inval_index;
	index_t     lookup_index;
	tag_t       lookup_tag;
	logic       hit;
	way_t       hit_way;
	logic       fill_we;
	way_t       fill_way;
	logic       fill_valid;
	logic       data_we;
	way_t       data_way;
	line_strb_t data_strb;
	line_t      data_wdata;
	line_t      data_rline;
	index_t     snoop_index;
	tag_t       snoop_tag;
	logic       snoop_hit;
	way_t       snoop_hit_way;
	logic       inval_we;
	way_t       inval_way;

	rw_controller rw_controller_inst (
		.clk_i             (clk_i),
		.rst_n             (rst_n),
		.i_init_done       (init_done),
		.i_rd_valid        (i_rd_valid),
		.o_rd_ready        (o_rd_ready),
		.i_rd_addr         (i_rd_addr),
		.o_rsp_valid       (o_rsp_valid),
		.i_rsp_ready       (i_rsp_ready),
		.o_rsp_data        (o_rsp_data),
		.i_wr_valid        (i_wr_valid),
		.o_wr_ready        (o_wr_ready),
		.i_wr_addr         (i_wr_addr),
		.i_wr_data         (i_wr_data),
		.i_wr_strb         (i_wr_strb),
		.o_wr_done         (o_wr_done),
		.o_mem_rd_valid    (o_mem_rd_valid),
		.i_mem_rd_ready    (i_mem_rd_ready),
		.o_mem_rd_addr     (o_mem_rd_addr),
		.i_mem_rdata_valid (i_mem_rdata_valid),
		.i_mem_rdata       (i_mem_rdata),
		.o_mem_wr_valid    (o_mem_wr_valid),
		.i_mem_wr_ready    (i_mem_wr_ready),
		.o_mem_wr_addr     (o_mem_wr_addr),
		.o_mem_wr_data     (o_mem_wr_data),
		.o_mem_wr_strb     (o_mem_wr_strb),
		.i_mem_wr_done     (i_mem_wr_done),
		.o_snoop_valid     (o_snoop_valid),
		.o_snoop_addr      (o_snoop_addr),
		.i_snoop_stall     (i_snoop_stall),
		.i_inval_seen      (inval_seen),
		.i_inval_index     (inval_index),
		.o_lookup_index    (lookup_index),
		.o_lookup_tag      (lookup_tag),
		.i_hit             (hit),
		.i_hit_way         (hit_way),
		.o_fill_we         (fill_we),
		.o_fill_way        (fill_way),
		.o_fill_valid      (fill_valid),
		.o_data_we         (data_we),
		.o_data_way        (data_way),
		.o_data_strb       (data_strb),
		.o_data_wdata      (data_wdata),
		.i_data_rline      (data_rline)
	);

	snoop_checker snoop_checker_inst (
		.clk_i           (clk_i),
		.rst_n           (rst_n),
		.i_snoop_valid   (i_snoop_valid),
		.i_snoop_addr    (i_snoop_addr),
		.o_snoop_busy    (o_snoop_busy),
		.o_snoop_index   (snoop_index),
		.o_snoop_tag     (snoop_tag),
		.i_snoop_hit     (snoop_hit),
		.i_snoop_hit_way (snoop_hit_way),
		.o_inval_we      (inval_we),
		.o_inval_way     (inval_way),
		.o_inval_seen    (inval_seen),
		.o_inval_index   (inval_index)
	);

	tag_store tag_store_inst (
		.clk_i           (clk_i),
		.rst_n           (rst_n),
		.o_init_done     (init_done),
		.i_lookup_index  (lookup_index),
		.i_lookup_tag    (lookup_tag),
		.o_hit           (hit),
		.o_hit_way       (hit_way),
		.i_fill_we       (fill_we),
		.i_fill_way      (fill_way),
		.i_fill_valid    (fill_valid),
		.i_snoop_index   (snoop_index),
		.i_snoop_tag     (snoop_tag),
		.o_snoop_hit     (snoop_hit),
		.o_snoop_hit_way (snoop_hit_way),
		.i_inval_we      (inval_we),
		.i_inval_way     (inval_way)
	);

	line_data_store line_data_store_inst (
		.clk_i   (clk_i),
		.i_index (lookup_index),
		.i_we    (data_we),
		.i_way   (data_way),
		.i_strb  (data_strb),
		.i_wdata (data_wdata),
		.o_rline (data_rline)
	);

endmodule

// File: tb/l1_cache_tb.sv
// ==========================================================================
// Testbench for the L1 data cache. Drives reads, writes and snoops into
// the top level against a sparse memory model and checks every response
// against a reference model of memory. Compiled through the file list.
// ==========================================================================
`include "cache_consts.svh"

module l1_cache_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import cache_pkg::*;

	// Directed tests take a few hundred cycles and each random op under 40
	localparam int MAX_CYCLES = 20000;

	logic        clk_i = 1'b0;
	logic        rst_n = 1'b0;
	logic        i_rd_valid = 1'b0;
	logic [31:0] i_rd_addr = '0;
	logic        i_rsp_ready = 1'b1;
	logic        i_wr_valid = 1'b0;
	logic [31:0] i_wr_addr = '0;
	logic [31:0] i_wr_data = '0;
	logic [3:0]  i_wr_strb = '0;
	logic        i_mem_rd_ready = 1'b1;
	logic        i_mem_rdata_valid = 1'b0;
	logic [31:0] i_mem_rdata = '0;
	logic        i_mem_wr_ready = 1'b1;
	logic        i_mem_wr_done = 1'b0;
	logic        i_snoop_valid = 1'b0;
	logic [31:0] i_snoop_addr = '0;
	logic        i_snoop_stall = 1'b0;
	logic        o_rd_ready;
	logic        o_rsp_valid;
	logic [31:0] o_rsp_data;
	logic        o_wr_ready;
	logic        o_wr_done;
	logic        o_mem_rd_valid;
	logic [31:0] o_mem_rd_addr;
	logic        o_mem_wr_valid;
	logic [31:0] o_mem_wr_addr;
	logic [31:0] o_mem_wr_data;
	logic [3:0]  o_mem_wr_strb;
	logic        o_snoop_busy;
	logic        o_snoop_valid;
	logic [31:0] o_snoop_addr;

	integer      seed;
	int          cycle = 0;
	int          errors = 0;
	int          rsp_count = 0;
	int          done_count = 0;
	int          mem_rd_count = 0;
	int          beats_left = 0;
	int          wr_wait = -1;
	logic        bp_on = 1'b0;
	logic        done_prev = 1'b0;
	logic [31:0] fill_base;
	logic [31:0] last_wr_addr = '0;
	logic [31:0] mem_rd_addr_seen = '0;
	logic [31:0] mem_wr_addr_seen = '0;
	logic [3:0]  mem_wr_strb_seen = '0;
	logic [31:0] mem_words [logic [31:0]];
	logic [31:0] ref_words [logic [31:0]];
	logic [31:0] exp_q [$];
	string       name_q [$];

	l1_cache_top l1_cache_top_inst (.*);

	initial begin
		forever #5 clk_i = ~clk_i;
	end

	// Unwritten memory holds a pattern of its own word address
	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return {a[23:0], a[31:24]} ^ a ^ 32'h5a0f_c3e1;
	endfunction

	function automatic logic [31:0] memory_word(input logic [31:0] a);
		logic [31:0] key;
		key = {a[31:2], 2'b00};
		return mem_words.exists(key) ? mem_words[key] : fill_word(key);
	endfunction

	function automatic logic [31:0] ref_read(input logic [31:0] a);
		logic [31:0] key;
		key = {a[31:2], 2'b00};
		return ref_words.exists(key) ? ref_words[key] : fill_word(key);
	endfunction

	function automatic void ref_write(input logic [31:0] a, input logic [31:0] d,
			input logic [3:0] strb);
		logic [31:0] w;
		w = ref_read(a);
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				w[b*8 +: 8] = d[b*8 +: 8];
			end
		end
		ref_words[{a[31:2], 2'b00}] = w;
	endfunction

	function automatic logic [31:0] make_addr(input logic [19:0] tag, input logic [7:0] idx,
			input logic [1:0] word);
		cache_addr_u a;
		a.f.tag    = tag;
		a.f.index  = idx;
		a.f.word   = word;
		a.f.offset = 2'b00;
		return a.raw;
	endfunction

	// Five lines share one index so the four ways overflow
	function automatic logic [31:0] pool_addr(input logic [2:0] k, input logic [1:0] word);
		if (k < 3'd5) begin
			return make_addr(20'h1_0000 + 20'(k), 8'h40, word);
		end
		return make_addr(20'h2_0000 + 20'(k), 8'h41 + 8'(k), word);
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Fail %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic read_word(input string name, input logic [31:0] addr, output int latency);
		int acc;
		int seen;
		@(posedge clk_i);
		i_rd_valid <= 1'b1;
		i_rd_addr  <= addr;
		@(negedge clk_i);
		while (!o_rd_ready) begin
			@(negedge clk_i);
		end
		acc  = cycle;
		seen = rsp_count;
		exp_q.push_back(ref_read(addr));
		name_q.push_back(name);
		@(posedge clk_i);
		i_rd_valid <= 1'b0;
		@(negedge clk_i);
		while (!o_rsp_valid) begin
			@(negedge clk_i);
		end
		latency = cycle - acc;
		while (rsp_count == seen) begin
			@(negedge clk_i);
		end
	endtask

	task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		int seen;
		@(posedge clk_i);
		i_wr_valid <= 1'b1;
		i_wr_addr  <= addr;
		i_wr_data  <= data;
		i_wr_strb  <= strb;
		@(negedge clk_i);
		while (!o_wr_ready) begin
			@(negedge clk_i);
		end
		ref_write(addr, data, strb);
		last_wr_addr = addr;
		seen = done_count;
		@(posedge clk_i);
		i_wr_valid <= 1'b0;
		@(negedge clk_i);
		while (done_count == seen) begin
			@(negedge clk_i);
		end
	endtask

	// Returns once the invalidation has been written
	task automatic send_snoop(input logic [31:0] addr);
		@(posedge clk_i);
		i_snoop_valid <= 1'b1;
		i_snoop_addr  <= addr;
		@(negedge clk_i);
		while (o_snoop_busy) begin
			@(negedge clk_i);
		end
		@(posedge clk_i);
		i_snoop_valid <= 1'b0;
		@(negedge clk_i);
		while (o_snoop_busy) begin
			@(negedge clk_i);
		end
	endtask

	always @(posedge clk_i) begin
		cycle <= cycle + 1;
		if (cycle >= MAX_CYCLES) begin
			$display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	always @(posedge clk_i) begin
		i_rsp_ready <= bp_on ? (($random(seed) & 3) != 0) : 1'b1;
	end

	// Memory model with four in-order beats per line and delayed write acks
	always @(posedge clk_i) begin
		i_mem_rdata_valid <= 1'b0;
		i_mem_wr_done     <= 1'b0;
		if (rst_n) begin
			if (beats_left > 0) begin
				i_mem_rdata_valid <= 1'b1;
				i_mem_rdata <= memory_word(fill_base + 32'((`WORDS_PER_LINE - beats_left) * 4));
				beats_left = beats_left - 1;
			end
			if (o_mem_rd_valid && i_mem_rd_ready) begin
				fill_base        = o_mem_rd_addr;
				mem_rd_addr_seen = o_mem_rd_addr;
				beats_left       = `WORDS_PER_LINE;
				mem_rd_count++;
			end
			if (wr_wait == 0) begin
				i_mem_wr_done <= 1'b1;
				wr_wait = -1;
			end else if (wr_wait > 0) begin
				wr_wait = wr_wait - 1;
			end
			if (o_mem_wr_valid && i_mem_wr_ready) begin
				mem_wr_addr_seen = o_mem_wr_addr;
				mem_wr_strb_seen = o_mem_wr_strb;
				for (int b = 0; b < 4; b++) begin
					if (o_mem_wr_strb[b]) begin
						mem_words[{o_mem_wr_addr[31:2], 2'b00}] =
							memory_word(o_mem_wr_addr) & ~(32'hff << (b*8)) |
							(o_mem_wr_data & (32'hff << (b*8)));
					end
				end
				wr_wait = $random(seed) & 3;
			end
		end
	end

	// Compare each accepted response with the reference
	always @(negedge clk_i) begin
		if (rst_n && o_rsp_valid && i_rsp_ready) begin
			if (exp_q.size() == 0) begin
				$display("A read response came with no read outstanding");
				errors++;
			end else begin
				check_value(name_q.pop_front(), exp_q.pop_front(), o_rsp_data);
			end
			rsp_count++;
		end
	end

	// Write completion and outgoing snoop
	always @(negedge clk_i) begin
		if (rst_n) begin
			check_value("wr_done_after_mem_done", 32'(done_prev), 32'(o_wr_done));
			check_value("snoop_out_with_done", 32'(done_prev), 32'(o_snoop_valid));
			if (o_wr_done) begin
				check_value("snoop_out_addr", last_wr_addr, o_snoop_addr);
				done_count++;
			end
		end
		done_prev = i_mem_wr_done;
	end

	initial begin
		logic [31:0] r;
		logic [31:0] addr;
		int          lat;
		int          rd0;
		int          delay;
		seed = 32'h33ba40ca;
		repeat (7) @(posedge clk_i);
		@(negedge clk_i);
		check_value("reset_outputs", 32'h0, 32'({o_rd_ready, o_wr_ready, o_rsp_valid,
			o_mem_rd_valid, o_mem_wr_valid, o_wr_done, o_snoop_valid, o_snoop_busy}));
		@(posedge clk_i);
		rst_n <= 1'b1;

		// Read miss, then hits in the same line
		rd0  = mem_rd_count;
		addr = make_addr(20'h00a1, 8'h08, 2'd1);
		read_word("miss_first", addr, lat);
		check_value("miss_mem_reads", rd0 + 1, mem_rd_count);
		check_value("miss_mem_addr", make_addr(20'h00a1, 8'h08, 2'd0), mem_rd_addr_seen);
		rd0 = mem_rd_count;
		read_word("hit_second", make_addr(20'h00a1, 8'h08, 2'd3), lat);
		check_value("hit_mem_reads", rd0, mem_rd_count);
		check_value("hit_latency", 3, lat);

		// Write-through on a hit
		addr = make_addr(20'h00a1, 8'h08, 2'd2);
		write_word(addr, 32'hdead_beef, 4'b0110);
		check_value("wt_mem_addr", addr, mem_wr_addr_seen);
		check_value("wt_mem_strb", 32'(4'b0110), 32'(mem_wr_strb_seen));
		rd0 = mem_rd_count;
		read_word("wt_merged", addr, lat);
		check_value("wt_mem_reads", rd0, mem_rd_count);

		// Write miss leaves the line uncached
		addr = make_addr(20'h00b2, 8'h09, 2'd0);
		write_word(addr, 32'h1234_5678, 4'b1111);
		check_value("wmiss_mem_addr", addr, mem_wr_addr_seen);
		rd0 = mem_rd_count;
		read_word("wmiss_read", addr, lat);
		check_value("wmiss_mem_reads", rd0 + 1, mem_rd_count);

		// Snoop on a cached line, then on another index
		read_word("snoop_fill", make_addr(20'h00c3, 8'h10, 2'd0), lat);
		send_snoop(make_addr(20'h00c3, 8'h10, 2'd1));
		rd0 = mem_rd_count;
		read_word("snoop_refetch", make_addr(20'h00c3, 8'h10, 2'd2), lat);
		check_value("snoop_hit_mem_reads", rd0 + 1, mem_rd_count);
		read_word("snoop_other_fill", make_addr(20'h00d4, 8'h20, 2'd0), lat);
		send_snoop(make_addr(20'h00d4, 8'h21, 2'd0));
		rd0 = mem_rd_count;
		read_word("snoop_other_read", make_addr(20'h00d4, 8'h20, 2'd1), lat);
		check_value("snoop_miss_mem_reads", rd0, mem_rd_count);

		// Outgoing snoop stall holds off new writes
		@(posedge clk_i);
		i_snoop_stall <= 1'b1;
		fork
			write_word(make_addr(20'h00e5, 8'h30, 2'd3), 32'hcafe_f00d, 4'b1001);
			begin
				repeat (20) begin
					@(negedge clk_i);
					check_value("stall_wr_ready", 32'h0, 32'(o_wr_ready));
				end
				@(posedge clk_i);
				i_snoop_stall <= 1'b0;
			end
		join

		// Random mix with response back-pressure
		bp_on = 1'b1;
		for (int i = 0; i < 300; i++) begin
			r     = $random(seed);
			addr  = pool_addr(r[2:0], r[4:3]);
			delay = int'(r[22:20]) + 1;
			case (r[10:8])
				3'd0, 3'd1, 3'd2: begin
					read_word("random_read", addr, lat);
				end
				3'd3: begin
					fork
						read_word("random_read_snooped", addr, lat);
						begin
							repeat (delay) @(posedge clk_i);
							send_snoop(pool_addr(r[18:16], 2'd0));
						end
					join
				end
				3'd4, 3'd5: begin
					write_word(addr, $random(seed), r[14:11]);
				end
				default: begin
					send_snoop(pool_addr(r[18:16], r[25:24]));
				end
			endcase
		end
		bp_on = 1'b0;

		repeat (10) @(posedge clk_i);
		if (exp_q.size() != 0) begin
			$display("%0d reads never got a response", exp_q.size());
			errors++;
		end
		$display("Run finished with %0d errors", errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: compile.f
+incdir+common
common/cache_pkg.sv
rtl/line_data_store.sv
l1_cache/tag_store.sv
l1_cache/snoop_checker.sv
l1_cache/rw_controller.sv
l1_cache/l1_cache_top.sv
tb/l1_cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the L1 cache testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module l1_cache_tb -o l1_cache_sim > build.log 2>&1 \
	&& ./obj_dir/l1_cache_sim > sim.log 2>&1 \
	|| { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "TEST FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TEST OK" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation passed"
exit 0
